/* design/mipsPkg.sv */
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;
    localparam int imemIdxWidth = $clog2(imemDepth);
    localparam int dmemIdxWidth = $clog2(dmemDepth);

    localparam logic [5:0] opR = 6'h00;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opJ = 6'h02;

    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    typedef enum logic {
        wbAlu,
        wbMem
    } wbSrcT;

    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } fwdSelT;

endpackage

/* design/fetch.sv */
`timescale 1ns/1ns

module fetch import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 stallF,
    input  logic                 clrD,
    input  logic                 stallD,
    input  logic [dataWidth-1:0] pcNext,
    input  logic                 imemWe,
    input  logic [dataWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0] imemData,
    output logic [dataWidth-1:0] instrD,
    output logic [dataWidth-1:0] pcPlus4F,
    output logic [dataWidth-1:0] pcPlus4D
);

    logic [dataWidth-1:0] pcF;
    logic [dataWidth-1:0] instrF;
    logic [dataWidth-1:0] imem [imemDepth];

    assign instrF = imem[pcF[imemIdxWidth+1:2]];
    assign pcPlus4F = pcF + 32'd4;

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[imemIdxWidth+1:2]] <= imemData; // program load while reset is held.
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= '0;
            instrD <= '0;
            pcPlus4D <= '0;
        end else begin
            if (!stallF) begin
                pcF <= pcNext;
            end
            if (!stallD) begin
                instrD <= clrD ? '0 : instrF; // an all-zero word decodes as a no-op.
                pcPlus4D <= pcPlus4F;
            end
        end
    end

endmodule

/* design/decode.sv */
`timescale 1ns/1ns

module decode import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    flushE,
    input  logic [dataWidth-1:0]    instrD,
    input  logic [dataWidth-1:0]    pcPlus4D,
    input  logic                    forwardAD,
    input  logic                    forwardBD,
    input  logic [dataWidth-1:0]    aluOutM,
    input  logic                    regWriteW,
    input  logic [regAddrWidth-1:0] writeRegW,
    input  logic [dataWidth-1:0]    resultW,
    output logic [regAddrWidth-1:0] rsD,
    output logic [regAddrWidth-1:0] rtD,
    output logic                    branchD,
    output logic                    jumpD,
    output logic                    pcSrcD,
    output logic [dataWidth-1:0]    pcBranchD,
    output logic [dataWidth-1:0]    jumpDstD,
    output logic                    regWriteE,
    output logic                    memWriteE,
    output wbSrcT                   wbSrcE,
    output aluOpT                   aluOpE,
    output logic                    aluSrcE,
    output logic                    regDstE,
    output logic [dataWidth-1:0]    rd1E,
    output logic [dataWidth-1:0]    rd2E,
    output logic [regAddrWidth-1:0] rsE,
    output logic [regAddrWidth-1:0] rtE,
    output logic [regAddrWidth-1:0] rdE,
    output logic [dataWidth-1:0]    immE
);

    logic [dataWidth-1:0] rf [2**regAddrWidth];
    logic [dataWidth-1:0] rd1D, rd2D, immD;
    logic [regAddrWidth-1:0] rdD;
    logic regWriteD, memWriteD, aluSrcD, regDstD;
    wbSrcT wbSrcD;
    aluOpT aluOpD;

    assign rsD = instrD[25:21];
    assign rtD = instrD[20:16];
    assign rdD = instrD[15:11];
    assign immD = {{16{instrD[15]}}, instrD[15:0]};

    always_comb begin
        regWriteD = 1'b0;
        memWriteD = 1'b0;
        wbSrcD = wbAlu;
        aluOpD = aluAdd;
        aluSrcD = 1'b0;
        regDstD = 1'b0;
        branchD = 1'b0;
        jumpD = 1'b0;
        case (instrD[31:26])
            opR: begin
                regWriteD = 1'b1;
                regDstD = 1'b1;
                case (instrD[5:0])
                    fnAdd: aluOpD = aluAdd;
                    fnSub: aluOpD = aluSub;
                    fnAnd: aluOpD = aluAnd;
                    fnOr: aluOpD = aluOr;
                    fnSlt: aluOpD = aluSlt;
                    default: regWriteD = 1'b0; // includes the all-zero bubble.
                endcase
            end
            opAddi: begin
                regWriteD = 1'b1;
                aluSrcD = 1'b1;
            end
            opLw: begin
                regWriteD = 1'b1;
                aluSrcD = 1'b1;
                wbSrcD = wbMem;
            end
            opSw: begin
                memWriteD = 1'b1;
                aluSrcD = 1'b1;
            end
            opBeq: branchD = 1'b1;
            opJ: jumpD = 1'b1;
            default: ;
        endcase
    end

    // written on the falling edge so the same-cycle read sees it.
    always_ff @(negedge clk) begin
        if (regWriteW) begin
            rf[writeRegW] <= resultW;
        end
    end

    assign rd1D = (rsD == '0) ? '0 : rf[rsD];
    assign rd2D = (rtD == '0) ? '0 : rf[rtD];

    assign pcSrcD = branchD && ((forwardAD ? aluOutM : rd1D) == (forwardBD ? aluOutM : rd2D));
    assign pcBranchD = pcPlus4D + {immD[dataWidth-3:0], 2'b00};
    assign jumpDstD = {pcPlus4D[31:28], instrD[25:0], 2'b00};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            wbSrcE <= wbAlu;
            aluOpE <= aluAdd;
            aluSrcE <= 1'b0;
            regDstE <= 1'b0;
        end else if (flushE) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            wbSrcE <= wbAlu;
            aluOpE <= aluAdd;
            aluSrcE <= 1'b0;
            regDstE <= 1'b0;
        end else begin
            regWriteE <= regWriteD;
            memWriteE <= memWriteD;
            wbSrcE <= wbSrcD;
            aluOpE <= aluOpD;
            aluSrcE <= aluSrcD;
            regDstE <= regDstD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E <= rd1D;
        rd2E <= rd2D;
        rsE <= rsD;
        rtE <= rtD;
        rdE <= rdD;
        immE <= immD;
    end

endmodule

/* design/execute.sv */
`timescale 1ns/1ns

module execute import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    regWriteE,
    input  logic                    memWriteE,
    input  wbSrcT                   wbSrcE,
    input  aluOpT                   aluOpE,
    input  logic                    aluSrcE,
    input  logic                    regDstE,
    input  logic [dataWidth-1:0]    rd1E,
    input  logic [dataWidth-1:0]    rd2E,
    input  logic [regAddrWidth-1:0] rtE,
    input  logic [regAddrWidth-1:0] rdE,
    input  logic [dataWidth-1:0]    immE,
    input  fwdSelT                  forwardAE,
    input  fwdSelT                  forwardBE,
    input  logic [dataWidth-1:0]    resultW,
    output logic [regAddrWidth-1:0] writeRegE,
    output logic                    regWriteM,
    output logic                    memWriteM,
    output wbSrcT                   wbSrcM,
    output logic [dataWidth-1:0]    aluOutM,
    output logic [dataWidth-1:0]    writeDataM,
    output logic [regAddrWidth-1:0] writeRegM
);

    logic [dataWidth-1:0] srcAE, srcBE, writeDataE, aluOutE;

    always_comb begin
        case (forwardAE)
            fwdMem: srcAE = aluOutM;
            fwdWb: srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (forwardBE)
            fwdMem: writeDataE = aluOutM;
            fwdWb: writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = aluSrcE ? immE : writeDataE;
    assign writeRegE = regDstE ? rdE : rtE;

    always_comb begin
        case (aluOpE)
            aluSub: aluOutE = srcAE - srcBE;
            aluAnd: aluOutE = srcAE & srcBE;
            aluOr: aluOutE = srcAE | srcBE;
            aluSlt: aluOutE = {31'd0, $signed(srcAE) < $signed(srcBE)};
            default: aluOutE = srcAE + srcBE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
            wbSrcM <= wbAlu;
        end else begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
            wbSrcM <= wbSrcE;
        end
    end

    always_ff @(posedge clk) begin
        aluOutM <= aluOutE;
        writeDataM <= writeDataE; // store data after forwarding.
        writeRegM <= writeRegE;
    end

endmodule

/* design/memory.sv */
`timescale 1ns/1ns

module memory import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    regWriteM,
    input  logic                    memWriteM,
    input  wbSrcT                   wbSrcM,
    input  logic [dataWidth-1:0]    aluOutM,
    input  logic [dataWidth-1:0]    writeDataM,
    input  logic [regAddrWidth-1:0] writeRegM,
    output logic                    regWriteW,
    output wbSrcT                   wbSrcW,
    output logic [dataWidth-1:0]    aluOutW,
    output logic [dataWidth-1:0]    readDataW,
    output logic [regAddrWidth-1:0] writeRegW
);

    logic [dataWidth-1:0] dmem [dmemDepth];

    always_ff @(posedge clk) begin
        if (memWriteM) begin
            dmem[aluOutM[dmemIdxWidth+1:2]] <= writeDataM;
        end
        aluOutW <= aluOutM;
        readDataW <= dmem[aluOutM[dmemIdxWidth+1:2]]; // word address, low bits ignored.
        writeRegW <= writeRegM;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
            wbSrcW <= wbAlu;
        end else begin
            regWriteW <= regWriteM;
            wbSrcW <= wbSrcM;
        end
    end

endmodule

/* design/writeback.sv */
`timescale 1ns/1ns

module writeback import mipsPkg::*; (
    input  wbSrcT                wbSrcW,
    input  logic [dataWidth-1:0] aluOutW,
    input  logic [dataWidth-1:0] readDataW,
    input  logic                 pcSrcD,
    input  logic                 jumpD,
    input  logic [dataWidth-1:0] jumpDstD,
    input  logic [dataWidth-1:0] pcBranchD,
    input  logic [dataWidth-1:0] pcPlus4F,
    output logic [dataWidth-1:0] resultW,
    output logic [dataWidth-1:0] pcNext
);

    assign resultW = (wbSrcW == wbMem) ? readDataW : aluOutW;

    always_comb begin
        if (jumpD) begin
            pcNext = jumpDstD;
        end else if (pcSrcD) begin
            pcNext = pcBranchD;
        end else begin
            pcNext = pcPlus4F;
        end
    end

endmodule

/* design/hazard.sv */
`timescale 1ns/1ns

module hazard import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] rsD,
    input  logic [regAddrWidth-1:0] rtD,
    input  logic                    branchD,
    input  logic                    jumpD,
    input  logic [regAddrWidth-1:0] rsE,
    input  logic [regAddrWidth-1:0] rtE,
    input  logic [regAddrWidth-1:0] writeRegE,
    input  logic                    regWriteE,
    input  wbSrcT                   wbSrcE,
    input  logic [regAddrWidth-1:0] writeRegM,
    input  logic                    regWriteM,
    input  wbSrcT                   wbSrcM,
    input  logic [regAddrWidth-1:0] writeRegW,
    input  logic                    regWriteW,
    output logic                    stallF,
    output logic                    stallD,
    output logic                    flushE,
    output logic                    forwardAD,
    output logic                    forwardBD,
    output fwdSelT                  forwardAE,
    output fwdSelT                  forwardBE
);

    logic run, lwStall, branchStall, stall;

    function automatic fwdSelT fwdSel(input logic [regAddrWidth-1:0] src);
        if (src != '0 && src == writeRegM && regWriteM) begin
            return fwdMem;
        end else if (src != '0 && src == writeRegW && regWriteW) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    // low for the first cycle out of reset while the pipeline is all bubbles.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign forwardAE = run ? fwdSel(rsE) : fwdNone;
    assign forwardBE = run ? fwdSel(rtE) : fwdNone;
    assign forwardAD = run && rsD != '0 && rsD == writeRegM && regWriteM;
    assign forwardBD = run && rtD != '0 && rtD == writeRegM && regWriteM;

    assign lwStall = wbSrcE == wbMem && (rtE == rsD || rtE == rtD) && !jumpD;
    assign branchStall = branchD &&
        ((regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
         (wbSrcM == wbMem && regWriteM && (writeRegM == rsD || writeRegM == rtD)));

    assign stall = run && (lwStall || branchStall);
    assign stallF = stall;
    assign stallD = stall;
    assign flushE = stall; // the held instruction leaves a bubble behind it.

endmodule

/* design/datapath.sv */
`timescale 1ns/1ns

module datapath import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    stallF,
    input  logic                    stallD,
    input  logic                    flushE,
    input  logic                    forwardAD,
    input  logic                    forwardBD,
    input  fwdSelT                  forwardAE,
    input  fwdSelT                  forwardBE,
    output logic [regAddrWidth-1:0] rsD,
    output logic [regAddrWidth-1:0] rtD,
    output logic                    branchD,
    output logic                    jumpD,
    output logic [regAddrWidth-1:0] rsE,
    output logic [regAddrWidth-1:0] rtE,
    output logic [regAddrWidth-1:0] writeRegE,
    output logic                    regWriteE,
    output wbSrcT                   wbSrcE,
    output logic [regAddrWidth-1:0] writeRegM,
    output logic                    regWriteM,
    output wbSrcT                   wbSrcM,
    output logic [regAddrWidth-1:0] writeRegW,
    output logic                    regWriteW,
    input  logic                    imemWe,
    input  logic [dataWidth-1:0]    imemAddr,
    input  logic [dataWidth-1:0]    imemData,
    output logic [dataWidth-1:0]    resultW,
    output logic                    memWriteM,
    output logic [dataWidth-1:0]    aluOutM,
    output logic [dataWidth-1:0]    writeDataM
);

    logic clrD, pcSrcD, memWriteE, aluSrcE, regDstE;
    logic [dataWidth-1:0] pcNext, instrD, pcPlus4F, pcPlus4D, pcBranchD, jumpDstD;
    logic [dataWidth-1:0] rd1E, rd2E, immE, aluOutW, readDataW;
    logic [regAddrWidth-1:0] rdE;
    aluOpT aluOpE;
    wbSrcT wbSrcW;

    assign clrD = pcSrcD | jumpD; // squash the slot behind a redirect.

    fetch fetchStage (.*);
    decode decodeStage (.*);
    execute executeStage (.*);
    memory memoryStage (.*);
    writeback writebackStage (.*);

endmodule

/* design/cpuTop.sv */
`timescale 1ns/1ns

module cpuTop import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    imemWe,
    input  logic [dataWidth-1:0]    imemAddr,
    input  logic [dataWidth-1:0]    imemData,
    output logic                    regWriteW,
    output logic [regAddrWidth-1:0] writeRegW,
    output logic [dataWidth-1:0]    resultW,
    output logic                    memWriteM,
    output logic [dataWidth-1:0]    aluOutM,
    output logic [dataWidth-1:0]    writeDataM
);

    logic stallF, stallD, flushE, forwardAD, forwardBD;
    logic branchD, jumpD, regWriteE, regWriteM;
    logic [regAddrWidth-1:0] rsD, rtD, rsE, rtE, writeRegE, writeRegM;
    wbSrcT wbSrcE, wbSrcM;
    fwdSelT forwardAE, forwardBE;

    datapath dp (.*);
    hazard hu (.*);

endmodule

/* verification/cpuTb.sv */
`timescale 1ns/1ns

module cpuTb import mipsPkg::*; ();

    localparam logic [dataWidth-1:0] markerAddr = 32'h0000_00fc;

    logic                    clk;
    logic                    rstN;
    logic                    imemWe;
    logic [dataWidth-1:0]    imemAddr;
    logic [dataWidth-1:0]    imemData;
    logic                    regWriteW;
    logic [regAddrWidth-1:0] writeRegW;
    logic [dataWidth-1:0]    resultW;
    logic                    memWriteM;
    logic [dataWidth-1:0]    aluOutM;
    logic [dataWidth-1:0]    writeDataM;

    logic [dataWidth-1:0]    prog [imemDepth];
    int                      progLen;
    logic [regAddrWidth-1:0] expIdx [$];
    logic [dataWidth-1:0]    expVal [$];
    logic [dataWidth-1:0]    expAddr [$];
    logic [dataWidth-1:0]    expData [$];
    logic [regAddrWidth-1:0] gotIdx [$];
    logic [dataWidth-1:0]    gotVal [$];
    logic [dataWidth-1:0]    gotAddr [$];
    logic [dataWidth-1:0]    gotData [$];
    logic                    markerSeen;
    int                      testErrors;
    int                      passedTests;
    int                      failedTests;
    int                      runCycles = 0;
    int                      cycleLimit = 0;

    cpuTop uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // the trace is sampled mid-cycle, where every output has settled.
    always @(negedge clk) begin
        if (!rstN) begin
            gotIdx.delete();
            gotVal.delete();
            gotAddr.delete();
            gotData.delete();
            markerSeen = 1'b0;
        end else begin
            if (regWriteW) begin
                gotIdx.push_back(writeRegW);
                gotVal.push_back(resultW);
            end
            if (memWriteM) begin
                gotAddr.push_back(aluOutM);
                gotData.push_back(writeDataM);
                if (aluOutM == markerAddr) begin
                    markerSeen = 1'b1; // the last store of every program.
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rstN) begin
            runCycles++;
            if (runCycles > cycleLimit) begin
                $display("timeout: %0d cycles out of reset, limit %0d", runCycles, cycleLimit);
                $display("Test failed");
                $finish;
            end
        end
    end

    function automatic logic [dataWidth-1:0] rType(input logic [5:0] fn, input int rd,
                                                   input int rs, input int rt);
        return {opR, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [dataWidth-1:0] iType(input logic [5:0] op, input int rt,
                                                   input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [dataWidth-1:0] jType(input int wordIdx);
        return {opJ, 26'(wordIdx)};
    endfunction

    // opcode and function code zero, so an unused word never writes anything.
    function automatic logic [dataWidth-1:0] fillWord(input int wordIdx);
        logic [5:0] w;
        w = 6'(wordIdx);
        return {6'h00, w, ~w, w, 2'b00, 6'h00};
    endfunction

    function automatic int randImm();
        return int'($urandom_range(32'hffff, 0));
    endfunction

    task automatic addInstr(input logic [dataWidth-1:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic finishProgram();
        addInstr(iType(opSw, 0, 0, int'(markerAddr)));
        addInstr(jType(progLen)); // jump to itself.
    endtask

    task automatic runModel();
        logic [dataWidth-1:0]    mreg [2**regAddrWidth];
        logic [dataWidth-1:0]    mmem [dmemDepth];
        logic [dataWidth-1:0]    pc, nextPc, ins, imm, a, b, res, target;
        logic [regAddrWidth-1:0] rs, rt, dst;
        logic                    wr;
        logic                    halted;
        int                      i;
        int                      steps;
        expIdx.delete();
        expVal.delete();
        expAddr.delete();
        expData.delete();
        for (i = 0; i < 2**regAddrWidth; i++) begin
            mreg[i] = '0;
        end
        for (i = 0; i < dmemDepth; i++) begin
            mmem[i] = '0;
        end
        pc = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 1000) begin
            ins = prog[pc[imemIdxWidth+1:2]];
            rs = ins[25:21];
            rt = ins[20:16];
            imm = {{16{ins[15]}}, ins[15:0]};
            a = mreg[rs];
            b = mreg[rt];
            nextPc = pc + 32'd4;
            wr = 1'b0;
            dst = rt;
            res = '0;
            case (ins[31:26])
                opR: begin
                    wr = 1'b1;
                    dst = ins[15:11];
                    case (ins[5:0])
                        fnAdd: res = a + b;
                        fnSub: res = a - b;
                        fnAnd: res = a & b;
                        fnOr: res = a | b;
                        fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opAddi: begin
                    wr = 1'b1;
                    res = a + imm;
                end
                opLw: begin
                    wr = 1'b1;
                    res = mmem[(a + imm) >> 2];
                end
                opSw: begin
                    expAddr.push_back(a + imm);
                    expData.push_back(b);
                    mmem[(a + imm) >> 2] = b;
                end
                opBeq: begin
                    if (a == b) begin
                        nextPc = nextPc + {imm[dataWidth-3:0], 2'b00};
                    end
                end
                opJ: begin
                    target = {nextPc[31:28], ins[25:0], 2'b00};
                    halted = (target == pc);
                    nextPc = target;
                end
                default: ;
            endcase
            if (wr) begin
                expIdx.push_back(dst);
                expVal.push_back(res);
                if (dst != '0) begin
                    mreg[dst] = res; // register 0 stays zero.
                end
            end
            pc = nextPc;
            steps++;
        end
        if (!halted) begin
            $display("reference model never reached the halt loop");
            testErrors++;
        end
    endtask

    task automatic compareRegWrite(input logic [regAddrWidth-1:0] wantIdx, seenIdx,
                                   input logic [dataWidth-1:0] wantVal, seenVal);
        if (seenIdx !== wantIdx) begin
            $display("MISMATCH writeRegW: expected 0x%0h, got 0x%0h", wantIdx, seenIdx);
            testErrors++;
        end
        if (seenVal !== wantVal) begin
            $display("MISMATCH resultW: expected 0x%08h, got 0x%08h", wantVal, seenVal);
            testErrors++;
        end
    endtask

    task automatic compareStore(input logic [dataWidth-1:0] wantAddr, seenAddr,
                                input logic [dataWidth-1:0] wantData, seenData);
        if (seenAddr !== wantAddr) begin
            $display("MISMATCH aluOutM: expected 0x%08h, got 0x%08h", wantAddr, seenAddr);
            testErrors++;
        end
        if (seenData !== wantData) begin
            $display("MISMATCH writeDataM: expected 0x%08h, got 0x%08h", wantData, seenData);
            testErrors++;
        end
    endtask

    task automatic checkTrace();
        int i;
        if (gotIdx.size() != expIdx.size()) begin
            $display("register writes: expected %0d, saw %0d", expIdx.size(), gotIdx.size());
            testErrors++;
        end
        for (i = 0; i < gotIdx.size() && i < expIdx.size(); i++) begin
            compareRegWrite(expIdx[i], gotIdx[i], expVal[i], gotVal[i]);
        end
        if (gotAddr.size() != expAddr.size()) begin
            $display("stores: expected %0d, saw %0d", expAddr.size(), gotAddr.size());
            testErrors++;
        end
        for (i = 0; i < gotAddr.size() && i < expAddr.size(); i++) begin
            compareStore(expAddr[i], gotAddr[i], expData[i], gotData[i]);
        end
    endtask

    task automatic runProgram(input string name);
        int i;
        testErrors = 0;
        runModel();
        cycleLimit = cycleLimit + 5 * progLen + 20;
        @(posedge clk);
        rstN <= 1'b0;
        for (i = 0; i < imemDepth; i++) begin
            @(posedge clk);
            imemWe <= 1'b1;
            imemAddr <= i * 4;
            imemData <= (i < progLen) ? prog[i] : fillWord(i);
        end
        @(posedge clk);
        imemWe <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        while (!markerSeen) begin
            @(posedge clk);
        end
        checkTrace();
        if (testErrors == 0) begin
            passedTests++;
            $display("PASS %s", name);
        end else begin
            failedTests++;
            $display("FAIL %s with %0d errors", name, testErrors);
        end
    endtask

    task automatic aluIndependentTest();
        int i;
        progLen = 0;
        for (i = 1; i <= 4; i++) begin
            addInstr(iType(opAddi, i, 0, randImm()));
        end
        addInstr(rType(fnAdd, 5, 1, 2));
        addInstr(rType(fnSub, 6, 3, 4));
        addInstr(rType(fnAnd, 7, 1, 3));
        addInstr(rType(fnOr, 8, 2, 4));
        addInstr(rType(fnSlt, 9, 1, 2));
        addInstr(rType(fnSlt, 10, 4, 3));
        addInstr(iType(opAddi, 11, 1, randImm()));
        finishProgram();
        runProgram("aluIndependent");
    endtask

    task automatic forwardChainTest();
        progLen = 0;
        addInstr(iType(opAddi, 1, 0, randImm()));
        addInstr(rType(fnAdd, 2, 1, 1));
        addInstr(rType(fnSub, 3, 2, 1)); // r2 from memory, r1 from writeback.
        addInstr(rType(fnOr, 4, 3, 2));
        addInstr(rType(fnAnd, 5, 4, 3));
        addInstr(rType(fnSlt, 6, 5, 1));
        addInstr(iType(opAddi, 7, 6, randImm()));
        addInstr(rType(fnAdd, 8, 7, 5));
        addInstr(iType(opAddi, 9, 0, randImm()));
        addInstr(iType(opAddi, 10, 0, randImm()));
        addInstr(rType(fnSub, 11, 9, 10));
        addInstr(rType(fnAdd, 12, 11, 9));
        finishProgram();
        runProgram("forwardChain");
    endtask

    task automatic storeLoadTest();
        progLen = 0;
        addInstr(iType(opAddi, 1, 0, 16'h0040));
        addInstr(iType(opAddi, 2, 0, randImm()));
        addInstr(iType(opSw, 2, 1, 0));
        addInstr(iType(opSw, 1, 1, 4));
        addInstr(iType(opLw, 3, 1, 0));
        addInstr(rType(fnAdd, 4, 3, 2)); // load-use bubble.
        addInstr(iType(opLw, 5, 1, 4));
        addInstr(iType(opSw, 5, 1, 8));
        addInstr(iType(opLw, 6, 1, 8));
        addInstr(rType(fnAdd, 7, 6, 4));
        finishProgram();
        runProgram("storeLoad");
    endtask

    task automatic branchJumpTest();
        progLen = 0;
        addInstr(iType(opAddi, 1, 0, 5));
        addInstr(iType(opAddi, 2, 0, 5));
        addInstr(iType(opBeq, 2, 1, 2)); // taken, skips the next two.
        addInstr(iType(opAddi, 3, 0, 111));
        addInstr(iType(opAddi, 3, 0, 222));
        addInstr(iType(opAddi, 4, 0, 7));
        addInstr(iType(opBeq, 1, 4, 1));
        addInstr(iType(opAddi, 5, 0, 9));
        addInstr(rType(fnSub, 6, 4, 4));
        addInstr(iType(opBeq, 0, 6, 1));
        addInstr(iType(opAddi, 7, 0, 1));
        addInstr(jType(13));
        addInstr(iType(opAddi, 8, 0, 1));
        addInstr(iType(opSw, 5, 0, 32));
        addInstr(iType(opLw, 9, 0, 32));
        addInstr(iType(opBeq, 5, 9, 1)); // waits for the load in memory.
        addInstr(iType(opAddi, 10, 0, 1));
        addInstr(iType(opAddi, 11, 9, 3));
        finishProgram();
        runProgram("branchJump");
    endtask

    task automatic zeroRegisterTest();
        progLen = 0;
        addInstr(iType(opAddi, 0, 0, randImm()));
        addInstr(rType(fnAdd, 1, 0, 0));
        addInstr(iType(opAddi, 2, 0, 5));
        addInstr(rType(fnAdd, 0, 2, 2));
        addInstr(rType(fnAdd, 3, 0, 2));
        addInstr(rType(fnOr, 4, 0, 0));
        addInstr(iType(opSw, 0, 0, 16));
        addInstr(iType(opLw, 5, 0, 16));
        addInstr(rType(fnAdd, 6, 5, 2));
        finishProgram();
        runProgram("zeroRegister");
    endtask

    initial begin
        void'($urandom(66));
        rstN = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        passedTests = 0;
        failedTests = 0;
        aluIndependentTest();
        forwardChainTest();
        storeLoadTest();
        branchJumpTest();
        zeroRegisterTest();
        $display("tests passed: %0d, failed: %0d", passedTests, failedTests);
        if (failedTests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
design/mipsPkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/writeback.sv
design/hazard.sv
design/datapath.sv
design/cpuTop.sv
verification/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := cpuTb
FLIST     := flist.f
OBJDIR    := obj_dir
PASSMSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
